/* project.f */
+incdir+.
decode_pkg.sv
decode_ctrl.sv
decode_bit_aligner.sv
decode_coeff_pack.sv
decode_top.sv
tb_decode.sv

/* Bender.yml */
package:
  name: decode

sources:
  - files:
      - decode_pkg.sv
      - decode_ctrl.sv
      - decode_bit_aligner.sv
      - decode_coeff_pack.sv
      - decode_top.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - tb_decode.sv

/* tb_decode_ref.svh */
// Reference model of the decoder: the expected output words of one frame,
// built from the LSB-first bit stream
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

typedef logic [7:0]  frame_t [];
typedef logic [63:0] word_arr_t [];

// Stream bit s is bit s%8 of byte s/8
function automatic logic stream_bit(input frame_t frame, input int s);
	return frame[s / 8][s % 8];
endfunction

// Input word idx of a frame, byte 0 in bits 7:0
function automatic logic [63:0] frame_word(input frame_t frame, input int idx);
	logic [63:0] word;
	for (int b = 0; b < 8; b++) begin
		word[8*b +: 8] = frame[8*idx + b];
	end
	return word;
endfunction

function automatic word_arr_t ref_decode(input frame_t frame, input int l);
	word_arr_t   words;
	logic [63:0] word;
	int          k;
	int          n_words;
	int          c;
	int          pos;
	k       = 64 / l;
	n_words = (256 + k - 1) / k;
	words   = new[n_words];
	for (int j = 0; j < n_words; j++) begin
		word = '0;
		for (int g = 0; g < k; g++) begin
			c = j * k + g;
			// Coefficients past the frame stay zero
			if (c < 256) begin
				for (int b = 0; b < l; b++) begin
					// Field g from the top, stream bit b is value bit b
					pos = 64 - l * (g + 1) + b;
					word[pos] = stream_bit(frame, c * l + b);
				end
			end
		end
		words[j] = word;
	end
	return words;
endfunction

`endif

/* tb_decode.sv */
// Testbench for the coefficient decoder: clock, reset, random frames,
// output comparison against the reference model, timeout and report
`timescale 1ns/1ns
`default_nettype none

module tb_decode;

	import decode_pkg::*;

	`include "tb_decode_ref.svh"

	// Six single frames and one back-to-back pair
	localparam int N_FRAMES   = 8;
	localparam int MAX_CYCLES = N_FRAMES * 70 + 10 + 50;

	logic           i_clk;
	logic           i_rstn;
	logic [63:0]    i_ibytes;
	logic           i_ibytes_valid;
	coeff_width_e   i_l;
	logic [63:0]    o_coeffs;
	logic           o_coeffs_valid;
	logic           o_ibytes_ready;
	logic           o_done;

	logic [63:0]    exp_q [$];
	logic [63:0]    last_word;
	int             valid_cnt;
	int             cycles;
	int             err_cnt;
	int             n_tests;
	int             n_failed;

	decode_top #(
		.DATA_W (64)
	) dut0 (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_ibytes       (i_ibytes),
		.i_ibytes_valid (i_ibytes_valid),
		.i_l            (i_l),
		.o_coeffs       (o_coeffs),
		.o_coeffs_valid (o_coeffs_valid),
		.o_ibytes_ready (o_ibytes_ready),
		.o_done         (o_done)
	);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("ERROR %s: got 0x%016h, expected 0x%016h", name, actual, expected);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			n_failed++;
			$display("test %s: failed with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// ----------------------------------------------------------
	// Output comparison, sampled mid-cycle
	// ----------------------------------------------------------
	always @(negedge i_clk) begin
		if (o_coeffs_valid) begin
			valid_cnt++;
			last_word = o_coeffs;
			if (exp_q.size() == 0) begin
				$display("Output word arrived with no expected word left");
				err_cnt++;
			end else begin
				check_value("o_coeffs", o_coeffs, exp_q.pop_front());
			end
		end
		if (o_done) begin
			if (!o_coeffs_valid || exp_q.size() != 0) begin
				$display("o_done did not come with the last output word");
				err_cnt++;
			end
		end
	end

	// ----------------------------------------------------------
	// One frame of random bytes
	// ----------------------------------------------------------
	task automatic run_frame(input coeff_width_e l);
		frame_t      frame;
		word_arr_t   words;
		logic [63:0] mask;
		logic        pending;
		int          n_in;
		int          idx;
		int          taken;
		int          remain;
		n_in  = 4 * int'(l);
		frame = new[8 * n_in];
		foreach (frame[i]) begin
			frame[i] = 8'($urandom);
		end
		words = ref_decode(frame, int'(l));
		foreach (words[j]) begin
			exp_q.push_back(words[j]);
		end
		valid_cnt = 0;
		taken     = 0;
		idx       = 0;
		@(negedge i_clk);
		i_l            = l;
		i_ibytes       = frame_word(frame, 0);
		i_ibytes_valid = 1'b1;
		pending        = o_ibytes_ready;
		// Ready seen mid-cycle tells whether the coming edge takes the word
		do begin
			@(negedge i_clk);
			i_ibytes_valid = 1'b0;
			if (pending) begin
				taken++;
				idx++;
				i_ibytes = (idx < n_in) ? frame_word(frame, idx) : {$urandom, $urandom};
			end
			pending = o_ibytes_ready;
		end while (!o_done);
		#1;
		check_value("valid words", valid_cnt, words.size());
		check_value("consumed words", taken, n_in);
		// Low bits below the last real coefficient
		remain = 256 - (words.size() - 1) * (64 / int'(l));
		if (remain * int'(l) < 64) begin
			mask = '0;
			for (int i = 0; i < 64 - remain * int'(l); i++) begin
				mask[i] = 1'b1;
			end
			check_value("o_coeffs fill", last_word & mask, 64'h0);
		end
	endtask

	initial begin
		int errs;
		void'($urandom(32'hbb29));
		i_clk          = 1'b0;
		i_rstn         = 1'b0;
		i_ibytes       = '0;
		i_ibytes_valid = 1'b0;
		i_l            = W1;
		cycles         = 0;
		err_cnt        = 0;
		n_tests        = 0;
		n_failed       = 0;
		valid_cnt      = 0;
		last_word      = '0;
		repeat (10) @(negedge i_clk);
		i_rstn = 1'b1;

		errs = err_cnt;
		@(negedge i_clk);
		check_value("o_ibytes_ready", o_ibytes_ready, 1);
		check_value("o_coeffs_valid", o_coeffs_valid, 0);
		check_value("o_done", o_done, 0);
		check_value("o_coeffs", o_coeffs, 0);
		report_test("reset", errs);

		foreach (WIDTHS[w]) begin
			errs = err_cnt;
			run_frame(WIDTHS[w]);
			report_test($sformatf("width %0d", int'(WIDTHS[w])), errs);
			repeat (3) @(negedge i_clk);
		end

		// Second frame starts on the cycle right after o_done
		errs = err_cnt;
		run_frame(W11);
		run_frame(W4);
		report_test("back-to-back widths 11 and 4", errs);
		repeat (3) @(negedge i_clk);

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* decode_top.sv */
// Decoder top level with controller, bit aligner and coefficient packer
`timescale 1ns/1ns
`default_nettype none

module decode_top #(
	parameter int DATA_W = decode_pkg::WORD_W
) (
	input  logic                       i_clk,
	input  logic                       i_rstn,
	input  logic [DATA_W-1:0]          i_ibytes,
	input  logic                       i_ibytes_valid,
	input  decode_pkg::coeff_width_e   i_l,
	output logic [DATA_W-1:0]          o_coeffs,
	output logic                       o_coeffs_valid,
	output logic                       o_ibytes_ready,
	output logic                       o_done
);

	import decode_pkg::*;

	dec_state_e            state;
	logic [OFFSET_W-1:0]   offset;
	logic                  hold;
	logic                  emit;
	logic [REMAIN_W-1:0]   remaining;
	logic [DATA_W-1:0]     window;

	decode_ctrl u_ctrl (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_ibytes_valid (i_ibytes_valid),
		.i_l            (i_l),
		.o_state        (state),
		.o_offset       (offset),
		.o_hold         (hold),
		.o_emit         (emit),
		.o_remaining    (remaining),
		.o_ibytes_ready (o_ibytes_ready),
		.o_coeffs_valid (o_coeffs_valid),
		.o_done         (o_done)
	);

	decode_bit_aligner #(
		.DATA_W (DATA_W)
	) u_align (
		.i_clk    (i_clk),
		.i_rstn   (i_rstn),
		.i_ibytes (i_ibytes),
		.i_state  (state),
		.i_offset (offset),
		.i_hold   (hold),
		.o_window (window)
	);

	decode_coeff_pack #(
		.DATA_W (DATA_W)
	) u_pack (
		.i_clk       (i_clk),
		.i_rstn      (i_rstn),
		.i_l         (i_l),
		.i_window    (window),
		.i_emit      (emit),
		.i_remaining (remaining),
		.o_coeffs    (o_coeffs)
	);

endmodule

`default_nettype wire

/* decode_coeff_pack.sv */
// Regroups the aligned window into MSB-first coefficient fields per width,
// zero-fills past the last coefficient and registers the output word
`timescale 1ns/1ns
`default_nettype none

module decode_coeff_pack #(
	parameter int DATA_W = decode_pkg::WORD_W
) (
	input  logic                              i_clk,
	input  logic                              i_rstn,
	input  decode_pkg::coeff_width_e          i_l,
	input  logic [DATA_W-1:0]                 i_window,
	input  logic                              i_emit,
	input  logic [decode_pkg::REMAIN_W-1:0]   i_remaining,
	output logic [DATA_W-1:0]                 o_coeffs
);

	import decode_pkg::*;

	logic [DATA_W-1:0]   packed_w [N_WIDTHS];
	logic [DATA_W-1:0]   coeffs_nx;

	// ----------------------------------------------------------
	// One field layout per supported width
	// ----------------------------------------------------------
	for (genvar w = 0; w < N_WIDTHS; w++) begin : g_width
		localparam int LW = int'(WIDTHS[w]);
		localparam int KW = DATA_W / LW;

		logic [DATA_W-1:0] word;

		// Group g sits at the top of the window, first stream bit first
		always_comb begin
			word = '0;
			for (int g = 0; g < KW; g++) begin
				for (int b = 0; b < LW; b++) begin
					// Stream bit b becomes field bit b
					word[DATA_W-LW*(g+1)+b] = i_window[DATA_W-1-g*LW-b]
						& (i_remaining > REMAIN_W'(g));
				end
			end
		end

		assign packed_w[w] = word;
	end

	// Width select, unsupported widths give zero
	always_comb begin
		coeffs_nx = '0;
		for (int w = 0; w < N_WIDTHS; w++) begin
			if (i_l == WIDTHS[w]) begin
				coeffs_nx = packed_w[w];
			end
		end
	end

	// ----------------------------------------------------------
	// Output register
	// ----------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			o_coeffs <= '0;
		end else if (i_emit) begin
			o_coeffs <= coeffs_nx;
		end
	end

endmodule

`default_nettype wire

/* decode_bit_aligner.sv */
// Input bit reordering, held word register and offset funnel shift
`timescale 1ns/1ns
`default_nettype none

module decode_bit_aligner #(
	parameter int DATA_W = decode_pkg::WORD_W
) (
	input  logic                              i_clk,
	input  logic                              i_rstn,
	input  logic [DATA_W-1:0]                 i_ibytes,
	input  decode_pkg::dec_state_e            i_state,
	input  logic [decode_pkg::OFFSET_W-1:0]   i_offset,
	input  logic                              i_hold,
	output logic [DATA_W-1:0]                 o_window
);

	import decode_pkg::*;

	localparam int N_BYTES = DATA_W / 8;

	logic [DATA_W-1:0]     rev;
	logic [DATA_W-1:0]     held;
	logic [2*DATA_W-1:0]   joined;

	// ----------------------------------------------------------
	// Stream order
	// ----------------------------------------------------------
	// Byte b moves to slot N_BYTES-1-b with its bits reversed,
	// so bit 0 of byte 0 ends up at the top
	always_comb begin
		for (int b = 0; b < N_BYTES; b++) begin
			for (int k = 0; k < 8; k++) begin
				rev[DATA_W-1-8*b-k] = i_ibytes[8*b+k];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_hold) begin
			held <= rev;
		end
	end

	// ----------------------------------------------------------
	// Funnel shift
	// ----------------------------------------------------------
	// Low i_offset bits of held, then the top of the new word
	assign joined   = {held, rev};
	assign o_window = joined[i_offset +: DATA_W];

	// Offset in range, and never empty once a frame is running
	a_offset_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(i_offset <= OFFSET_W'(DATA_W)) && (i_state == S_IDLE || i_offset != '0))
		else $error("offset %0d out of range in state %s", i_offset, i_state.name());

endmodule

`default_nettype wire

/* decode_ctrl.sv */
// Frame FSM, carry offset tracking, output word counter and
// remaining-coefficient count for the decoder
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
	input  logic                              i_clk,
	input  logic                              i_rstn,
	input  logic                              i_ibytes_valid,
	input  decode_pkg::coeff_width_e          i_l,
	output decode_pkg::dec_state_e            o_state,
	output logic [decode_pkg::OFFSET_W-1:0]   o_offset,
	output logic                              o_hold,
	output logic                              o_emit,
	output logic [decode_pkg::REMAIN_W-1:0]   o_remaining,
	output logic                              o_ibytes_ready,
	output logic                              o_coeffs_valid,
	output logic                              o_done
);

	import decode_pkg::*;

	dec_state_e            state;
	dec_state_e            state_nx;
	logic [OFFSET_W-1:0]   offset;
	logic [OFFSET_W-1:0]   carry;
	logic [OFFSET_W-1:0]   used_bits;
	logic [COUNT_W-1:0]    cnt;
	logic [COUNT_W-1:0]    cnt_last;
	logic                  working;
	logic                  stall;

	// Per-width constants
	assign carry     = OFFSET_W'(carry_bits(i_l));
	assign used_bits = OFFSET_W'(WORD_W - carry_bits(i_l));
	assign cnt_last  = COUNT_W'(last_word_index(i_l));

	assign working = (state == S_COMP) || (state == S_STALL);

	// Held bits alone cover a full output word
	assign stall = (offset + carry) > OFFSET_W'(WORD_W);

	// ----------------------------------------------------------
	// FSM
	// ----------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state <= S_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		case (state)
			S_IDLE: begin
				state_nx = i_ibytes_valid ? S_COMP : S_IDLE;
			end
			S_COMP,
			S_STALL: begin
				if (cnt == cnt_last) begin
					state_nx = S_DONE;
				end else if (stall) begin
					state_nx = S_STALL;
				end else begin
					state_nx = S_COMP;
				end
			end
			default: begin
				state_nx = S_IDLE;
			end
		endcase
	end

	// ----------------------------------------------------------
	// Offset and word counter
	// ----------------------------------------------------------
	// Offset counts unconsumed bits in the held word, full at frame start
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			offset <= '0;
		end else if (working) begin
			offset <= stall ? offset - used_bits : offset + carry;
		end else begin
			offset <= OFFSET_W'(WORD_W);
		end
	end

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			cnt <= '0;
		end else if (working) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			o_coeffs_valid <= 1'b0;
		end else begin
			o_coeffs_valid <= working;
		end
	end

	assign o_remaining = REMAIN_W'(N_COEFFS)
		- REMAIN_W'(cnt) * REMAIN_W'(coeffs_per_word(i_l));

	assign o_state        = state;
	assign o_offset       = offset;
	assign o_hold         = (state_nx == S_STALL);
	assign o_emit         = working;
	assign o_ibytes_ready = (state == S_IDLE) || (state_nx == S_COMP);
	assign o_done         = (state == S_DONE);

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	a_width_ok: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(state == S_IDLE && i_ibytes_valid) |-> (i_l inside {WIDTHS}))
		else $error("unsupported coefficient width %0d at frame start", i_l);

	a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_done |=> !o_done)
		else $error("o_done high in two consecutive cycles");

endmodule

`default_nettype wire

/* decode_pkg.sv */
// Shared constants, width and state enums, and per-width helper functions
// for the coefficient decoder
`default_nettype none

package decode_pkg;

	localparam int WORD_W   = 64;
	localparam int OFFSET_W = 7;
	localparam int COUNT_W  = 6;
	localparam int N_COEFFS = 256;
	localparam int REMAIN_W = $clog2(N_COEFFS + 1);

	// Encodings equal the coefficient width L
	typedef enum logic [3:0] {
		W1  = 4'd1,
		W4  = 4'd4,
		W5  = 4'd5,
		W10 = 4'd10,
		W11 = 4'd11,
		W12 = 4'd12
	} coeff_width_e;

	typedef enum logic [1:0] {
		S_IDLE,
		S_STALL,
		S_COMP,
		S_DONE
	} dec_state_e;

	localparam int N_WIDTHS = 6;
	localparam coeff_width_e WIDTHS [N_WIDTHS] = '{W1, W4, W5, W10, W11, W12};

	function automatic int coeffs_per_word(input coeff_width_e l);
		if (int'(l) == 0) begin
			return 0;
		end
		return WORD_W / int'(l);
	endfunction

	function automatic int carry_bits(input coeff_width_e l);
		return WORD_W - coeffs_per_word(l) * int'(l);
	endfunction

	function automatic int last_word_index(input coeff_width_e l);
		int k;
		k = coeffs_per_word(l);
		if (k == 0) begin
			return 0;
		end
		return (N_COEFFS + k - 1) / k - 1;
	endfunction

endpackage

`default_nettype wire
